// File: include/l2_mem_params.svh
// Geometry and data widths of the L2 memory subsystem
// Included by the package and by every RTL module that sizes a port or a loop
// Change L2_ADDR_WIDTH for a real build, the rest stays fixed

`ifndef L2_MEM_PARAMS_SVH
`define L2_MEM_PARAMS_SVH

////////////////////
// Array geometry
////////////////////

// Row address bits, 256 rows for simulation
// Real builds use 13, 15, 17 or 18
`define L2_ADDR_WIDTH 8

// One row of the array
`define L2_DATA_WIDTH 64

// One enable per byte of a row
`define L2_BE_WIDTH 8

////////////////////
// Fetch side
////////////////////

// Width of one fetched instruction, half a row
`define L2_INSTR_WIDTH 32

`endif

// File: logic/l2_mem_pkg.sv
// Shared types of the L2 memory subsystem
// Row, instruction and byte-enable types plus the data-port opcode
// Modules pull these in with a wildcard import in their header

`include "l2_mem_params.svh"

package l2_mem_pkg;

   ////////////////////
   // Data types
   ////////////////////

   // Full row as stored in the array and seen on the cluster bus
   typedef logic [`L2_DATA_WIDTH-1:0] l2_data_t;

   // Instruction word, one half of a row
   typedef logic [`L2_INSTR_WIDTH-1:0] l2_instr_t;

   // Byte enables, bit i covers byte i of the row
   typedef logic [`L2_BE_WIDTH-1:0] l2_ben_t;

   ////////////////////
   // Data-port opcode
   ////////////////////

   // Decoded from the active-low csn and wen strobes
   // IDLE when csn is high, READ with wen high, WRITE with wen low
   typedef enum logic [1:0]
   {
      L2_OP_IDLE  = 2'b00,
      L2_OP_READ  = 2'b01,
      L2_OP_WRITE = 2'b10
   } l2_op_e;

endpackage

// File: logic/l2_data_port.sv
// Front end of the cluster data bus on port A of the L2 array
// Turns the active-low csn and wen strobes into an opcode, an enable and
// a per-byte write strobe; address and write data bypass this block
// Purely combinational, the clock only samples the bus checks

`include "l2_mem_params.svh"

module l2_data_port
   import l2_mem_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_ni,

   // Cluster bus strobes, active low
   input  logic    mem_csn_i,
   input  logic    mem_wen_i,
   input  l2_ben_t mem_ben_i,

   // Port A controls towards the array
   output logic    port_a_en_o,
   output l2_ben_t port_a_we_o,
   output l2_op_e  port_a_op_o
);

   ////////////////////
   // Strobe decode
   ////////////////////

   // Opcode from the two strobes
   always_comb
   begin
      port_a_op_o = L2_OP_IDLE;
      // Access taken on every edge with csn low
      if (!mem_csn_i)
      begin
         if (mem_wen_i)
         begin
            // Whole row read
            port_a_op_o = L2_OP_READ;
         end
         else
         begin
            // Byte-masked write
            port_a_op_o = L2_OP_WRITE;
         end
      end
   end

   // Enable for reads and writes alike
   assign port_a_en_o = (port_a_op_o != L2_OP_IDLE);

   // Byte strobe only on a write, reads leave the row untouched
   assign port_a_we_o = mem_ben_i & {`L2_BE_WIDTH{port_a_op_o == L2_OP_WRITE}};

   ////////////////////
   // Bus checks
   ////////////////////

   // Write without any enabled byte is a malformed bus access
   a_write_ben_nonzero : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (!mem_csn_i && !mem_wen_i) |-> (mem_ben_i != '0)
   ) else $error("data port write with all-zero ben");

   // ben must be known whenever an access is taken
   a_ben_known : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      !mem_csn_i |-> !$isunknown(mem_ben_i)
   ) else $error("data port ben is X during an access");

endmodule

// File: logic/l2_instr_port.sv
// Instruction fetch front end on port B of the L2 array
// Grants every request at once and returns a 32-bit instruction with a
// valid pulse one cycle later; bit 2 of the byte address picks the half
// One fetch per cycle, no back-pressure on the response

`include "l2_mem_params.svh"

module l2_instr_port
   import l2_mem_pkg::*;
#(
   parameter int unsigned MEM_ADDR_WIDTH = `L2_ADDR_WIDTH
)
(
   input  logic                      clk_i,
   input  logic                      rst_ni,

   // Core fetch interface
   input  logic                      instr_req_i,
   input  logic [31:0]               instr_addr_i,
   output logic                      instr_gnt_o,
   output logic                      instr_r_valid_o,
   output l2_instr_t                 instr_r_rdata_o,

   // Port B of the array
   output logic                      port_b_en_o,
   output logic [MEM_ADDR_WIDTH-1:0] port_b_addr_o,
   input  l2_data_t                  port_b_rdata_i
);

   // Half select of the fetch in flight
   logic hi_sel_q;

   ////////////////////
   // Request side
   ////////////////////

   // Always ready, grant mirrors the request
   assign instr_gnt_o = instr_req_i;

   // Row lookup started in the request cycle
   assign port_b_en_o   = instr_req_i;
   // Byte address to row, bits 2:0 index inside the row
   assign port_b_addr_o = instr_addr_i[MEM_ADDR_WIDTH+2:3];

   ////////////////////
   // Response side
   ////////////////////

   // Valid follows the request by one cycle
   always_ff @(posedge clk_i)
   begin
      if (!rst_ni)
      begin
         instr_r_valid_o <= 1'b0;
      end
      else
      begin
         instr_r_valid_o <= instr_req_i;
      end
   end

   // Remember which half was asked for, held while no request
   always_ff @(posedge clk_i)
   begin
      if (instr_req_i)
      begin
         hi_sel_q <= instr_addr_i[2];
      end
   end

   // Pick the half from the registered row, upper half for bit 2 set
   assign instr_r_rdata_o = hi_sel_q ?
                            port_b_rdata_i[2*`L2_INSTR_WIDTH-1:`L2_INSTR_WIDTH] :
                            port_b_rdata_i[`L2_INSTR_WIDTH-1:0];

   ////////////////////
   // Checks
   ////////////////////

   // No spurious pulse, each valid belongs to the request one cycle before
   a_valid_after_req : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      instr_r_valid_o |-> $past(instr_req_i)
   ) else $error("instr_r_valid_o without a request in the previous cycle");

endmodule

// File: logic/l2_ram_dp_array.sv
// Behavioral dual-port storage of the L2 memory
// Port A reads and byte-writes, port B only reads; both read first, so a
// write returns the old row and a same-row read on B sees the old content
// Output registers clear on reset and load only when their port is enabled

`include "l2_mem_params.svh"

module l2_ram_dp_array
   import l2_mem_pkg::*;
#(
   parameter int unsigned MEM_ADDR_WIDTH = `L2_ADDR_WIDTH
)
(
   input  logic                      clk_i,
   input  logic                      rst_ni,

   // Port A, cluster data side
   input  logic                      port_a_en_i,
   input  l2_ben_t                   port_a_we_i,
   input  l2_op_e                    port_a_op_i,
   input  logic [MEM_ADDR_WIDTH-1:0] port_a_addr_i,
   input  l2_data_t                  port_a_wdata_i,
   output l2_data_t                  port_a_rdata_o,

   // Port B, instruction fetch side
   input  logic                      port_b_en_i,
   input  logic [MEM_ADDR_WIDTH-1:0] port_b_addr_i,
   output l2_data_t                  port_b_rdata_o
);

   // Row count and byte width
   localparam int unsigned NUM_ROWS  = 2**MEM_ADDR_WIDTH;
   localparam int unsigned BYTE_BITS = `L2_DATA_WIDTH / `L2_BE_WIDTH;

   // Storage, no reset and no preload
   l2_data_t mem_q [NUM_ROWS];

   ////////////////////
   // Port A
   ////////////////////

   // Byte-masked write
   always_ff @(posedge clk_i)
   begin
      if (port_a_en_i)
      begin
         for (int i = 0; i < `L2_BE_WIDTH; i++)
         begin
            if (port_a_we_i[i])
            begin
               mem_q[port_a_addr_i][i*BYTE_BITS +: BYTE_BITS] <=
                  port_a_wdata_i[i*BYTE_BITS +: BYTE_BITS];
            end
         end
      end
   end

   // Read first, old row even on a write
   // Held until the next access on this port
   always_ff @(posedge clk_i)
   begin
      if (!rst_ni)
      begin
         port_a_rdata_o <= '0;
      end
      else if (port_a_en_i)
      begin
         port_a_rdata_o <= mem_q[port_a_addr_i];
      end
   end

   ////////////////////
   // Port B
   ////////////////////

   // Read only; same edge as a port A write to this row gives the old row
   always_ff @(posedge clk_i)
   begin
      if (!rst_ni)
      begin
         port_b_rdata_o <= '0;
      end
      else if (port_b_en_i)
      begin
         port_b_rdata_o <= mem_q[port_b_addr_i];
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   // Byte strobe from the decoder only together with a write opcode
   a_we_only_on_write : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (port_a_we_i != '0) |-> (port_a_en_i && port_a_op_i == L2_OP_WRITE)
   ) else $error("port A byte strobe outside a write");

endmodule

// File: logic/l2_mem_top.sv
// Top level of the L2 memory subsystem
// Cluster data bus on port A and core instruction fetch on port B of one
// shared dual-port array; instances and wires only

`include "l2_mem_params.svh"

module l2_mem_top
   import l2_mem_pkg::*;
#(
   parameter int unsigned MEM_ADDR_WIDTH = `L2_ADDR_WIDTH
)
(
   input  logic                      clk_i,
   input  logic                      rst_ni,

   // Cluster data bus, active-low strobes, word address
   input  logic                      mem_csn_i,
   input  logic                      mem_wen_i,
   input  l2_ben_t                   mem_ben_i,
   input  logic [MEM_ADDR_WIDTH-1:0] mem_add_i,
   input  l2_data_t                  mem_wdata_i,
   output l2_data_t                  mem_rdata_o,

   // Core instruction fetch, byte address
   input  logic                      instr_req_i,
   input  logic [31:0]               instr_addr_i,
   output logic                      instr_gnt_o,
   output logic                      instr_r_valid_o,
   output l2_instr_t                 instr_r_rdata_o
);

   // Port A controls
   logic                      port_a_en;
   l2_ben_t                   port_a_we;
   l2_op_e                    port_a_op;

   // Port B lookup and row
   logic                      port_b_en;
   logic [MEM_ADDR_WIDTH-1:0] port_b_addr;
   l2_data_t                  port_b_rdata;

   ////////////////////
   // Front ends
   ////////////////////

   l2_data_port data_port_i (
      .clk_i       ( clk_i     ),
      .rst_ni      ( rst_ni    ),
      .mem_csn_i   ( mem_csn_i ),
      .mem_wen_i   ( mem_wen_i ),
      .mem_ben_i   ( mem_ben_i ),
      .port_a_en_o ( port_a_en ),
      .port_a_we_o ( port_a_we ),
      .port_a_op_o ( port_a_op )
   );

   l2_instr_port #(
      .MEM_ADDR_WIDTH ( MEM_ADDR_WIDTH )
   ) instr_port_i (
      .clk_i           ( clk_i           ),
      .rst_ni          ( rst_ni          ),
      .instr_req_i     ( instr_req_i     ),
      .instr_addr_i    ( instr_addr_i    ),
      .instr_gnt_o     ( instr_gnt_o     ),
      .instr_r_valid_o ( instr_r_valid_o ),
      .instr_r_rdata_o ( instr_r_rdata_o ),
      .port_b_en_o     ( port_b_en       ),
      .port_b_addr_o   ( port_b_addr     ),
      .port_b_rdata_i  ( port_b_rdata    )
   );

   ////////////////////
   // Shared storage
   ////////////////////

   // Address and write data go straight from the bus to port A
   l2_ram_dp_array #(
      .MEM_ADDR_WIDTH ( MEM_ADDR_WIDTH )
   ) ram_i (
      .clk_i          ( clk_i        ),
      .rst_ni         ( rst_ni       ),
      .port_a_en_i    ( port_a_en    ),
      .port_a_we_i    ( port_a_we    ),
      .port_a_op_i    ( port_a_op    ),
      .port_a_addr_i  ( mem_add_i    ),
      .port_a_wdata_i ( mem_wdata_i  ),
      .port_a_rdata_o ( mem_rdata_o  ),
      .port_b_en_i    ( port_b_en    ),
      .port_b_addr_i  ( port_b_addr  ),
      .port_b_rdata_o ( port_b_rdata )
   );

endmodule

// File: dv/tb_l2_mem_top.sv
// Self-checking testbench of the L2 memory subsystem
// Drives the cluster data bus and the fetch port of l2_mem_top, mirrors every
// write in a shadow array and checks both ports on every clock edge
// Built from flist.f with tb_l2_mem_top as top module

`include "l2_mem_params.svh"

module tb_l2_mem_top
   import l2_mem_pkg::*;
();

   localparam int unsigned AW        = `L2_ADDR_WIDTH;
   localparam int unsigned NUM_ROWS  = 2**AW;
   localparam int unsigned NUM_PART  = 64;
   localparam int unsigned NUM_FETCH = 64;
   localparam int unsigned NUM_COLL  = 8;
   localparam int unsigned NUM_MIXED = 300;
   // Reset, idle gaps, every phase and the final drain edge
   localparam int unsigned STIM_CYCLES = 10 + 3 + 2*NUM_ROWS + 4 + 2*NUM_PART + 2
                                         + NUM_FETCH + 2 + 3*NUM_COLL + NUM_MIXED + 5;
   localparam int unsigned MAX_CYCLES  = 2*STIM_CYCLES + 50;

   logic          clk = 1'b0;
   logic          rst_n;
   logic          mem_csn;
   logic          mem_wen;
   l2_ben_t       mem_ben;
   logic [AW-1:0] mem_add;
   l2_data_t      mem_wdata;
   l2_data_t      mem_rdata;
   logic          instr_req;
   logic [31:0]   instr_addr;
   logic          instr_gnt;
   logic          instr_r_valid;
   l2_instr_t     instr_r_rdata;

   // Checker state
   string         test_name;
   l2_data_t      shadow_mem [NUM_ROWS];
   l2_data_t      exp_row_q [$];
   l2_instr_t     exp_instr_q [$];
   l2_data_t      a_hold = '0;
   int unsigned   rng_state = 32'd26;
   int unsigned   cycle_cnt = 0;

   l2_mem_top #(
      .MEM_ADDR_WIDTH ( AW )
   ) dut_i (
      .clk_i           ( clk           ),
      .rst_ni          ( rst_n         ),
      .mem_csn_i       ( mem_csn       ),
      .mem_wen_i       ( mem_wen       ),
      .mem_ben_i       ( mem_ben       ),
      .mem_add_i       ( mem_add       ),
      .mem_wdata_i     ( mem_wdata     ),
      .mem_rdata_o     ( mem_rdata     ),
      .instr_req_i     ( instr_req     ),
      .instr_addr_i    ( instr_addr    ),
      .instr_gnt_o     ( instr_gnt     ),
      .instr_r_valid_o ( instr_r_valid ),
      .instr_r_rdata_o ( instr_r_rdata )
   );

   // 8-unit period
   always #4 clk = ~clk;

   ////////////////////
   // Random source
   ////////////////////

   function automatic int unsigned lcg_next();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   // Upper bits, the low LCG bits repeat too fast
   function automatic logic [AW-1:0] rand_row();
      int unsigned r;
      r = lcg_next();
      return r[31:32-AW];
   endfunction

   function automatic l2_data_t rand_data();
      return {lcg_next(), lcg_next()};
   endfunction

   // Never all zero, that would be a malformed write
   function automatic l2_ben_t rand_ben();
      int unsigned r;
      l2_ben_t     b;
      r = lcg_next();
      b = r[16 +: `L2_BE_WIDTH];
      if (b == '0)
         b = l2_ben_t'(1);
      return b;
   endfunction

   // Byte address of one half of a row
   function automatic logic [31:0] fetch_addr(input logic [AW-1:0] row, input logic hi);
      return {{(29-AW){1'b0}}, row, hi, 2'b00};
   endfunction

   ////////////////////
   // Reference model
   ////////////////////

   // Only the enabled bytes take the new data
   function automatic l2_data_t merge_bytes(input l2_data_t old_row, input l2_data_t wdata,
                                            input l2_ben_t ben);
      l2_data_t row;
      row = old_row;
      for (int i = 0; i < `L2_BE_WIDTH; i++)
      begin
         if (ben[i])
            row[i*8 +: 8] = wdata[i*8 +: 8];
      end
      return row;
   endfunction

   function automatic l2_data_t ref_row(input logic [AW-1:0] row);
      return shadow_mem[row];
   endfunction

   // Row from bits AW+2:3, half from bit 2
   function automatic l2_instr_t ref_instr(input logic [31:0] addr);
      l2_data_t row_data;
      row_data = ref_row(addr[AW+2:3]);
      if (addr[2])
         return row_data[2*`L2_INSTR_WIDTH-1:`L2_INSTR_WIDTH];
      else
         return row_data[`L2_INSTR_WIDTH-1:0];
   endfunction

   ////////////////////
   // Checks
   ////////////////////

   task automatic fail_run(input string msg);
      $display("ERROR: %s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input l2_data_t exp, input l2_data_t act);
      if (act !== exp)
      begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         $display("RESULT: FAIL");
         $fatal(1);
      end
   endtask

   task automatic check_instr(input string name, input l2_instr_t exp, input l2_instr_t act);
      if (act !== exp)
      begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         $display("RESULT: FAIL");
         $fatal(1);
      end
   endtask

   // Inputs are sampled before this edge's drive updates land
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         // Responses to the accesses taken one edge earlier
         if (exp_row_q.size() != 0)
            a_hold = exp_row_q.pop_front();
         check_data(test_name, a_hold, mem_rdata);
         if (exp_instr_q.size() != 0)
         begin
            if (!instr_r_valid)
               fail_run("missing instr_r_valid pulse one cycle after a fetch request");
            check_instr(test_name, exp_instr_q.pop_front(), instr_r_rdata);
         end
         else if (instr_r_valid)
            fail_run("instr_r_valid pulse without a fetch request in the previous cycle");
         if (instr_gnt !== instr_req)
            fail_run("instr_gnt_o does not equal instr_req_i");
         // Port B first, so a same-edge write is not yet visible to it
         if (instr_req)
            exp_instr_q.push_back(ref_instr(instr_addr));
         if (!mem_csn)
         begin
            // Read first on port A, write or not
            exp_row_q.push_back(ref_row(mem_add));
            if (!mem_wen)
               shadow_mem[mem_add] = merge_bytes(shadow_mem[mem_add], mem_wdata, mem_ben);
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > MAX_CYCLES)
         fail_run("timeout, the test did not finish within its cycle limit");
   end

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic drive_cycle(input logic a_act, input logic a_wr, input logic [AW-1:0] row,
                              input l2_data_t wdata, input l2_ben_t ben,
                              input logic f_req, input logic [31:0] f_addr);
      @(posedge clk);
      mem_csn    <= ~a_act;
      mem_wen    <= ~a_wr;
      mem_add    <= row;
      mem_wdata  <= wdata;
      mem_ben    <= ben;
      instr_req  <= f_req;
      instr_addr <= f_addr;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, 1'b0, '0, '0, '1, 1'b0, '0);
   endtask

   initial
   begin
      logic [AW-1:0] row_v;
      logic [AW-1:0] part_rows [NUM_PART];
      int unsigned   r;

      rst_n      <= 1'b0;
      mem_csn    <= 1'b1;
      mem_wen    <= 1'b1;
      mem_ben    <= '1;
      mem_add    <= '0;
      mem_wdata  <= '0;
      instr_req  <= 1'b0;
      instr_addr <= '0;
      test_name  <= "reset";
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;

      // Nothing accessed yet, rdata must stay zero
      test_name <= "after_reset";
      idle_cycles(3);

      // Every row written whole, then read back
      test_name <= "full_row";
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         row_v = i[AW-1:0];
         drive_cycle(1'b1, 1'b1, row_v, rand_data(), '1, 1'b0, '0);
      end
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         row_v = i[AW-1:0];
         drive_cycle(1'b1, 1'b0, row_v, '0, '1, 1'b0, '0);
      end
      idle_cycles(4);

      test_name <= "partial_ben";
      for (int i = 0; i < NUM_PART; i++)
      begin
         part_rows[i] = rand_row();
         drive_cycle(1'b1, 1'b1, part_rows[i], rand_data(), rand_ben(), 1'b0, '0);
      end
      for (int i = 0; i < NUM_PART; i++)
         drive_cycle(1'b1, 1'b0, part_rows[i], '0, '1, 1'b0, '0);
      idle_cycles(2);

      // One fetch per cycle, random rows and halves
      test_name <= "fetch_b2b";
      for (int i = 0; i < NUM_FETCH; i++)
      begin
         r = lcg_next();
         drive_cycle(1'b0, 1'b0, '0, '0, '1, 1'b1, fetch_addr(rand_row(), r[20]));
      end
      idle_cycles(2);

      test_name <= "collision";
      for (int i = 0; i < NUM_COLL; i++)
      begin
         row_v = rand_row();
         r = lcg_next();
         // Same edge, fetch gets the old row
         drive_cycle(1'b1, 1'b1, row_v, rand_data(), '1, 1'b1, fetch_addr(row_v, r[20]));
         // Next edge sees the new row
         drive_cycle(1'b0, 1'b0, row_v, '0, '1, 1'b1, fetch_addr(row_v, r[21]));
         idle_cycles(1);
      end

      // Bit 24 access, bit 25 write, bit 26 fetch, bit 27 half
      test_name <= "mixed";
      for (int i = 0; i < NUM_MIXED; i++)
      begin
         r = lcg_next();
         drive_cycle(r[24], r[25], rand_row(), rand_data(), rand_ben(),
                     r[26], fetch_addr(rand_row(), r[27]));
      end
      idle_cycles(4);

      @(posedge clk);
      if (exp_row_q.size() != 0 || exp_instr_q.size() != 0)
      begin
         $display("ERROR: responses still outstanding at the end of the test");
         $display("RESULT: FAIL");
         $fatal(1);
      end
      else
      begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

// File: flist.f
+incdir+include
logic/l2_mem_pkg.sv
logic/l2_data_port.sv
logic/l2_instr_port.sv
logic/l2_ram_dp_array.sv
logic/l2_mem_top.sv
dv/tb_l2_mem_top.sv

// File: run.sh
#!/bin/sh
# Builds the L2 memory testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

TOP=tb_l2_mem_top
OBJ=obj_dir

# Compile RTL and testbench from the file list
verilator --binary --timing --assert \
   -f flist.f \
   --top-module "$TOP" \
   -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

# Run and keep the output in memory only
out=$("./$OBJ/V$TOP" 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Pass only on the exact pass line
if printf '%s\n' "$out" | grep -q -x "RESULT: PASS"; then
   echo "Simulation passed"
   exit 0
else
   echo "Pass line not found in simulation output"
   exit 1
fi
